// ==== design/dac_drv.sv ====
// BCK_DIV must be even and at least 2; a zero frame is played whenever the queue is empty
module dac_drv #(
    parameter int DAC_DEPTH = 2,
    parameter int BCK_DIV   = 8
) (
    input  logic      clk491520,
    input  logic      rst_ip,
    frame_if.receiver in,
    output logic      dac_bck_o,
    output logic      dac_lrck_o,
    output logic      dac_data_o
);

    localparam int SB = $bits(dmix_pkg::sample_t);
    localparam int BW = $clog2(2 * dmix_pkg::SLOT_BITS);
    localparam int DW = (BCK_DIV > 2) ? $clog2(BCK_DIV) : 1;
    localparam int QW = (DAC_DEPTH > 1) ? $clog2(DAC_DEPTH) : 1;
    localparam int CW = $clog2(DAC_DEPTH + 1);

    dmix_pkg::frame_t queue [DAC_DEPTH];
    dmix_pkg::frame_t cur;
    dmix_pkg::sample_t side;
    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [DW-1:0] div_cnt;
    logic [BW-1:0] bit_cnt;
    logic [BW-1:0] nxt_bit;
    logic [BW-2:0] slot_pos;
    logic tick;
    logic take;

    function automatic logic [QW-1:0] bump(input logic [QW-1:0] ptr);
        return (ptr == QW'(DAC_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // last clock of a bck period, bck falls next
    assign tick = (div_cnt == DW'(BCK_DIV - 1));
    assign nxt_bit = bit_cnt + 1'b1;
    assign slot_pos = nxt_bit[BW-2:0];
    assign side = nxt_bit[BW-1] ? cur.right : cur.left;

    // next frame is taken where lrck falls into the left slot
    assign take = tick && (nxt_bit == '0) && (count != '0);

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in.credit <= 1'b0;
        end else begin
            in.credit <= take;
            if (in.valid) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (take) begin
                rd_ptr <= bump(rd_ptr);
            end
            count <= count + CW'(in.valid) - CW'(take);
        end
    end

    always_ff @(posedge clk491520) begin
        if (in.valid) begin
            queue[wr_ptr] <= in.frame_data();
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            cur <= '0;
            dac_bck_o <= 1'b0;
            dac_lrck_o <= 1'b0;
            dac_data_o <= 1'b0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (div_cnt == DW'(BCK_DIV / 2 - 1)) begin
                dac_bck_o <= 1'b1;
            end
            if (tick) begin
                dac_bck_o <= 1'b0;
                bit_cnt <= nxt_bit;
                // low is left
                dac_lrck_o <= nxt_bit[BW-1];
                if (nxt_bit == '0) begin
                    cur <= (count != '0) ? queue[rd_ptr] : '0;
                end
                // msb one bck after the lrck edge, zero pad after the lsb
                if (slot_pos != '0 && int'(slot_pos) <= SB) begin
                    dac_data_o <= side[SB - int'(slot_pos)];
                end else begin
                    dac_data_o <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== design/dmix_pkg.sv ====
// 24-bit samples in 32-bit I2S slots; gain is Q8.8 with 256 as unity; SLOT_BITS must stay a power of two
package dmix_pkg;

    localparam int SAMPLE_BITS = 24;
    localparam int GAIN_BITS = 16;

    // fraction bits of the Q8.8 gain
    localparam int GAIN_FRAC = 8;

    // bck periods per I2S half frame
    localparam int SLOT_BITS = 32;

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;
    typedef logic [GAIN_BITS-1:0] gain_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } frame_t;

    // saturation limits of sample_t
    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_BITS - 1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_BITS - 1){1'b0}}};

endpackage

// ==== design/dmix_top.sv ====
// single input, single clock domain; RING_DEPTH a power of two, BCK_DIV even
module dmix_top #(
    parameter int RING_DEPTH = 8,
    parameter int DAC_DEPTH  = 2,
    parameter int BCK_DIV    = 8
) (
    input  logic              clk491520,
    input  logic              rst_ip,
    input  logic              locked_i,
    input  logic              valid_i,
    input  logic              lrck_i,
    input  dmix_pkg::sample_t sample_i,
    input  dmix_pkg::gain_t   gain_l_i,
    input  dmix_pkg::gain_t   gain_r_i,
    output logic              overrun_o,
    output logic              dac_bck_o,
    output logic              dac_lrck_o,
    output logic              dac_data_o
);

    frame_if asm_link ();
    frame_if ring_link ();
    frame_if dac_link ();

    frame_assembler #(
        .RING_DEPTH(RING_DEPTH)
    ) i_frame_assembler (
        .clk491520(clk491520),
        .rst_ip   (rst_ip),
        .locked_i (locked_i),
        .valid_i  (valid_i),
        .lrck_i   (lrck_i),
        .sample_i (sample_i),
        .overrun_o(overrun_o),
        .out      (asm_link.sender)
    );

    // ring credits toward the mixer match the DAC queue
    frame_ring #(
        .RING_DEPTH(RING_DEPTH),
        .OUT_DEPTH (DAC_DEPTH)
    ) i_frame_ring (
        .clk491520(clk491520),
        .rst_ip   (rst_ip),
        .locked_i (locked_i),
        .in       (asm_link.receiver),
        .out      (ring_link.sender)
    );

    gain_mixer i_gain_mixer (
        .clk491520(clk491520),
        .rst_ip   (rst_ip),
        .gain_l_i (gain_l_i),
        .gain_r_i (gain_r_i),
        .in       (ring_link.receiver),
        .out      (dac_link.sender)
    );

    dac_drv #(
        .DAC_DEPTH(DAC_DEPTH),
        .BCK_DIV  (BCK_DIV)
    ) i_dac_drv (
        .clk491520 (clk491520),
        .rst_ip    (rst_ip),
        .in        (dac_link.receiver),
        .dac_bck_o (dac_bck_o),
        .dac_lrck_o(dac_lrck_o),
        .dac_data_o(dac_data_o)
    );

endmodule

// ==== design/frame_assembler.sv ====
// upstream cannot stall, so a frame completed without credit is dropped and sets sticky overrun
module frame_assembler #(
    parameter int RING_DEPTH = 8
) (
    input  logic              clk491520,
    input  logic              rst_ip,
    input  logic              locked_i,
    input  logic              valid_i,
    input  logic              lrck_i,
    input  dmix_pkg::sample_t sample_i,
    output logic              overrun_o,
    frame_if.sender           out
);

    localparam int CW = $clog2(RING_DEPTH + 1);

    logic [CW-1:0] credits;
    logic pend_vld;
    dmix_pkg::sample_t pend_left;
    logic complete;
    logic send;

    // right word closes a frame only when a left word is waiting
    assign complete = locked_i && valid_i && lrck_i && pend_vld;
    assign send = complete && (credits != '0);

    // credits survive loss of lock, the ring pays them back
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            credits <= CW'(RING_DEPTH);
        end else begin
            credits <= credits + CW'(out.credit) - CW'(send);
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip || !locked_i) begin
            pend_vld <= 1'b0;
            out.valid <= 1'b0;
            overrun_o <= 1'b0;
        end else begin
            out.valid <= send;
            // any right word consumes the pending left
            if (valid_i) begin
                pend_vld <= !lrck_i;
            end
            if (complete && !send) begin
                overrun_o <= 1'b1;
            end
        end
    end

    // a second left word replaces the first
    always_ff @(posedge clk491520) begin
        if (valid_i && !lrck_i) begin
            pend_left <= sample_i;
        end
        if (send) begin
            out.left <= pend_left;
            out.right <= sample_i;
        end
    end

endmodule

// ==== design/frame_if.sv ====
// one stereo frame per valid cycle; the sender may raise valid only while it holds a credit
interface frame_if;

    logic valid;
    dmix_pkg::sample_t left;
    dmix_pkg::sample_t right;

    // one pulse returns one credit to the sender
    logic credit;

    // both halves packed for storage on the receiving side
    function automatic dmix_pkg::frame_t frame_data();
        return '{left: left, right: right};
    endfunction

    modport sender (
        output valid,
        output left,
        output right,
        input  credit
    );

    modport receiver (
        input  valid,
        input  left,
        input  right,
        output credit,
        import frame_data
    );

endinterface

// ==== design/frame_ring.sv ====
// RING_DEPTH must be a power of two of at least 2; OUT_DEPTH is the downstream DAC queue depth
module frame_ring #(
    parameter int RING_DEPTH = 8,
    parameter int OUT_DEPTH  = 2
) (
    input  logic      clk491520,
    input  logic      rst_ip,
    input  logic      locked_i,
    frame_if.receiver in,
    frame_if.sender   out
);

    localparam int AW = $clog2(RING_DEPTH);
    localparam int CW = $clog2(RING_DEPTH + 1);
    localparam int OW = $clog2(OUT_DEPTH + 1);

    dmix_pkg::frame_t mem [RING_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] ret_cnt;
    logic [CW-1:0] ret_add;
    logic [OW-1:0] out_credits;
    logic wr_en;
    logic rd_en;

    assign wr_en = in.valid && locked_i;
    assign rd_en = locked_i && (count != '0) && (out_credits != '0);

    // oldest entry is visible the cycle after it was written
    assign out.valid = rd_en;
    assign out.left = mem[rd_ptr].left;
    assign out.right = mem[rd_ptr].right;

    // owed credits drain one pulse per cycle
    assign in.credit = (ret_cnt != '0);

    // flush pays back every held entry plus one arriving this cycle
    assign ret_add = locked_i ? CW'(rd_en) : count + CW'(in.valid);

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            ret_cnt <= '0;
            out_credits <= OW'(OUT_DEPTH);
        end else begin
            out_credits <= out_credits + OW'(out.credit) - OW'(rd_en);
            ret_cnt <= ret_cnt - CW'(in.credit) + ret_add;
            if (!locked_i) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (rd_en) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + CW'(wr_en) - CW'(rd_en);
            end
        end
    end

    always_ff @(posedge clk491520) begin
        if (wr_en) begin
            mem[wr_ptr] <= in.frame_data();
        end
    end

endmodule

// ==== design/gain_mixer.sv ====
// no frame storage here, so upstream credit only follows the DAC queue handing a slot back
module gain_mixer (
    input  logic            clk491520,
    input  logic            rst_ip,
    input  dmix_pkg::gain_t gain_l_i,
    input  dmix_pkg::gain_t gain_r_i,
    frame_if.receiver       in,
    frame_if.sender         out
);

    localparam int SB = $bits(dmix_pkg::sample_t);
    localparam int PW = SB + $bits(dmix_pkg::gain_t) + 1;

    logic s1_vld;
    logic signed [PW-1:0] prod_l;
    logic signed [PW-1:0] prod_r;

    // drop the gain fraction and clamp to the sample range
    function automatic dmix_pkg::sample_t saturate(input logic signed [PW-1:0] prod);
        logic signed [PW-1:0] scaled;
        scaled = prod >>> dmix_pkg::GAIN_FRAC;
        if (scaled > dmix_pkg::SAMPLE_MAX) begin
            return dmix_pkg::SAMPLE_MAX;
        end else if (scaled < dmix_pkg::SAMPLE_MIN) begin
            return dmix_pkg::SAMPLE_MIN;
        end
        return scaled[SB-1:0];
    endfunction

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            s1_vld <= 1'b0;
            out.valid <= 1'b0;
            in.credit <= 1'b0;
        end else begin
            s1_vld <= in.valid;
            out.valid <= s1_vld;
            // each DAC slot freed lets the ring send one more frame
            in.credit <= out.credit;
        end
    end

    // stage 1, signed sample times unsigned gain
    always_ff @(posedge clk491520) begin
        if (in.valid) begin
            prod_l <= in.left * $signed({1'b0, gain_l_i});
            prod_r <= in.right * $signed({1'b0, gain_r_i});
        end
    end

    // stage 2
    always_ff @(posedge clk491520) begin
        if (s1_vld) begin
            out.left <= saturate(prod_l);
            out.right <= saturate(prod_r);
        end
    end

endmodule

// ==== flist.f ====
design/dmix_pkg.sv
design/frame_if.sv
design/frame_assembler.sv
design/frame_ring.sv
design/gain_mixer.sv
design/dac_drv.sv
design/dmix_top.sv
tests/dmix_asserts.sv
tests/dmix_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds dmix_tb with Verilator, runs it, and exits nonzero unless the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dmix_tb -f flist.f -o dmix_sim &&
sim_out="$(./obj_dir/dmix_sim)" ;
printf '%s\n' "$sim_out" ;
printf '%s\n' "$sim_out" | grep -qx "RESULT: PASS" && echo "simulation passed" ||
{ echo "simulation failed" ; exit 1 ; }

// ==== tests/dmix_asserts.sv ====
// bound into frame_ring and dac_drv; ports a target lacks are tied low at the bind
module dmix_asserts #(
    parameter int DEPTH = 2
) (
    input logic       clk491520,
    input logic       rst_ip,
    input logic [7:0] fill_i,
    input logic       snd_valid_i,
    input logic [7:0] snd_credits_i,
    input logic       bck_i,
    input logic       lrck_i,
    input logic       data_i
);

    // occupancy never above the credits handed out
    a_fill: assert property (@(posedge clk491520) disable iff (rst_ip) fill_i <= 8'(DEPTH))
        else $error("receiver holds more frames than its depth");

    a_credit: assert property (@(posedge clk491520) disable iff (rst_ip)
        snd_valid_i |-> snd_credits_i != '0)
        else $error("sender raised valid without credit");

    // lrck and data move only where bck falls
    a_lrck: assert property (@(posedge clk491520) disable iff (rst_ip)
        $changed(lrck_i) |-> $fell(bck_i))
        else $error("lrck changed away from a bck falling edge");

    a_data: assert property (@(posedge clk491520) disable iff (rst_ip)
        $changed(data_i) |-> $fell(bck_i))
        else $error("data changed away from a bck falling edge");

    a_reset: assert property (@(posedge clk491520)
        $fell(rst_ip) |-> !snd_valid_i && !bck_i && !lrck_i && !data_i)
        else $error("outputs not idle when reset released");

endmodule

// ==== tests/dmix_tb.sv ====
// default depths and BCK_DIV only; the I2S capture drops all-zero frames, so the table has none
module dmix_tb;

    localparam int BCK_DIV = 8;
    localparam int SB = $bits(dmix_pkg::sample_t);
    localparam int FRAME_CYCLES = 2 * dmix_pkg::SLOT_BITS * BCK_DIV;
    localparam int NROWS = 5;
    localparam int NLIST = 21;

    logic clk491520 = 1'b0;
    logic rst_ip;
    logic locked_i;
    logic valid_i;
    logic lrck_i;
    dmix_pkg::sample_t sample_i;
    dmix_pkg::gain_t gain_l_i;
    dmix_pkg::gain_t gain_r_i;
    logic overrun_o;
    logic dac_bck_o;
    logic dac_lrck_o;
    logic dac_data_o;

    // rows with a nonzero base play synthesized left/right words instead of the list
    string row_name [NROWS] = '{"unity", "gain_scale", "pairing", "burst", "relock"};
    int row_first [NROWS] = '{0, 6, 14, 0, 0};
    int row_cnt [NROWS] = '{6, 8, 7, 40, 20};
    dmix_pkg::sample_t row_base [NROWS] = '{24'h0, 24'h0, 24'h0, 24'h200000, 24'h0f0f0f};
    dmix_pkg::gain_t row_gl [NROWS] = '{16'd256, 16'd128, 16'd256, 16'd256, 16'd512};
    dmix_pkg::gain_t row_gr [NROWS] = '{16'd256, 16'd640, 16'd256, 16'd256, 16'd256};
    bit row_burst [NROWS] = '{0, 0, 0, 1, 0};
    bit row_flush [NROWS] = '{0, 0, 0, 1, 0};
    bit row_ovr [NROWS] = '{0, 0, 0, 1, 0};

    // {lrck, sample}, lrck high marks a right word
    logic [24:0] word_list [NLIST] = '{
        {1'b0, 24'h123456}, {1'b1, 24'h0abcde},
        {1'b0, 24'hf00001}, {1'b1, 24'h7fffff},
        {1'b0, 24'h000010}, {1'b1, 24'h800000},
        {1'b0, 24'h100000}, {1'b1, 24'h040000},
        {1'b0, 24'hfffe00}, {1'b1, 24'h300000},
        {1'b0, 24'h400000}, {1'b1, 24'h400000},
        {1'b0, 24'h7fff00}, {1'b1, 24'hc00000},
        {1'b1, 24'h111111}, {1'b0, 24'h222222},
        {1'b0, 24'h333333}, {1'b1, 24'h444444},
        {1'b1, 24'h555555}, {1'b0, 24'h666666},
        {1'b1, 24'h777777}
    };

    bit pend = 1'b0;
    dmix_pkg::sample_t pend_left;
    dmix_pkg::frame_t exp_q [$];
    dmix_pkg::frame_t got [$];
    dmix_pkg::frame_t cap_f;
    dmix_pkg::sample_t cap_l;
    dmix_pkg::sample_t cap_r;
    logic prev_lrck = 1'b0;
    int pos = -1;
    int zero_cnt = 0;
    bit data_seen = 1'b0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;

    dmix_top #(
        .BCK_DIV(BCK_DIV)
    ) i_dmix_top (
        .clk491520 (clk491520),
        .rst_ip    (rst_ip),
        .locked_i  (locked_i),
        .valid_i   (valid_i),
        .lrck_i    (lrck_i),
        .sample_i  (sample_i),
        .gain_l_i  (gain_l_i),
        .gain_r_i  (gain_r_i),
        .overrun_o (overrun_o),
        .dac_bck_o (dac_bck_o),
        .dac_lrck_o(dac_lrck_o),
        .dac_data_o(dac_data_o)
    );

    // free ring space seen from the receiving side stands in for the assembler credits
    bind frame_ring dmix_asserts #(.DEPTH(RING_DEPTH)) i_ring_asserts (
        .clk491520(clk491520), .rst_ip(rst_ip), .fill_i(8'(count)),
        .snd_valid_i(wr_en), .snd_credits_i(8'(RING_DEPTH) - 8'(count) - 8'(ret_cnt)),
        .bck_i(1'b0), .lrck_i(1'b0), .data_i(1'b0));
    bind dac_drv dmix_asserts #(.DEPTH(DAC_DEPTH)) i_dac_asserts (
        .clk491520(clk491520), .rst_ip(rst_ip), .fill_i(8'(count)),
        .snd_valid_i(1'b0), .snd_credits_i(8'd0),
        .bck_i(dac_bck_o), .lrck_i(dac_lrck_o), .data_i(dac_data_o));

    always #20 clk491520 = ~clk491520;

    always @(posedge clk491520) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // rebuild frames from the I2S lines, data is stable while bck is high
    always @(posedge dac_bck_o) begin
        if (dac_data_o) begin
            data_seen = 1'b1;
        end
        if (dac_lrck_o == prev_lrck) begin
            pos = pos + 1;
        end else begin
            pos = 0;
            // lrck fell, so the right slot of the last frame is complete
            if (!dac_lrck_o) begin
                cap_f = '{left: cap_l, right: cap_r};
                if (cap_f == '0) begin
                    zero_cnt = zero_cnt + 1;
                end else begin
                    got.push_back(cap_f);
                end
            end
        end
        prev_lrck = dac_lrck_o;
        if (pos >= 1 && pos <= SB) begin
            if (dac_lrck_o) begin
                cap_r = {cap_r[SB-2:0], dac_data_o};
            end else begin
                cap_l = {cap_l[SB-2:0], dac_data_o};
            end
        end
    end

    // Q8.8 product, floor shift, clamp to the 24-bit range
    function automatic dmix_pkg::sample_t scale(dmix_pkg::sample_t s, dmix_pkg::gain_t g);
        longint p;
        p = (longint'(s) * longint'(g)) >>> dmix_pkg::GAIN_FRAC;
        if (p > longint'(dmix_pkg::SAMPLE_MAX)) begin
            return dmix_pkg::SAMPLE_MAX;
        end else if (p < longint'(dmix_pkg::SAMPLE_MIN)) begin
            return dmix_pkg::SAMPLE_MIN;
        end
        return p[SB-1:0];
    endfunction

    function automatic logic [24:0] word_of(int r, int k);
        dmix_pkg::sample_t s;
        if (row_base[r] == '0) begin
            return word_list[row_first[r] + k];
        end
        s = row_base[r] + 24'(k * 32'h010203);
        return {k[0], s};
    endfunction

    // pairing rule of the assembler
    task automatic model_word(logic [24:0] w, dmix_pkg::gain_t gl, dmix_pkg::gain_t gr);
        dmix_pkg::frame_t f;
        if (!w[24]) begin
            pend = 1'b1;
            pend_left = w[23:0];
        end else if (pend) begin
            pend = 1'b0;
            f.left = scale(pend_left, gl);
            f.right = scale(w[23:0], gr);
            exp_q.push_back(f);
        end
    endtask

    task automatic drive_word(logic [24:0] w);
        @(posedge clk491520);
        valid_i <= 1'b1;
        lrck_i <= w[24];
        sample_i <= w[23:0];
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk491520);
            valid_i <= 1'b0;
        end
    endtask

    task automatic check_frame(string name, dmix_pkg::frame_t exp, dmix_pkg::frame_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h/%h actual %h/%h", name,
                     exp.left, exp.right, act.left, act.right);
        end
    endtask

    task automatic check_flag(string name, bit exp, bit act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic run_row(int r);
        int z0;
        int idx;
        logic [24:0] w;
        got.delete();
        exp_q.delete();
        @(posedge clk491520);
        gain_l_i <= row_gl[r];
        gain_r_i <= row_gr[r];
        for (int k = 0; k < row_cnt[r]; k++) begin
            w = word_of(r, k);
            idle(row_burst[r] ? 0 : int'($urandom % 4));
            drive_word(w);
            model_word(w, row_gl[r], row_gr[r]);
        end
        idle(8);
        @(negedge clk491520);
        check_flag({row_name[r], " overrun"}, row_ovr[r], overrun_o);
        if (row_flush[r]) begin
            @(posedge clk491520);
            locked_i <= 1'b0;
            pend = 1'b0;
            repeat (4) @(posedge clk491520);
            locked_i <= 1'b1;
            @(negedge clk491520);
            check_flag({row_name[r], " relock"}, 1'b0, overrun_o);
        end
        // two silent frames mean the chain has run dry
        z0 = zero_cnt;
        while (zero_cnt < z0 + 2) begin
            @(posedge clk491520);
        end
        if (row_ovr[r]) begin
            idx = 0;
            checks++;
            for (int i = 0; i < got.size(); i++) begin
                while (idx < exp_q.size() && exp_q[idx] != got[i]) begin
                    idx++;
                end
                if (idx >= exp_q.size()) begin
                    errors++;
                    $display("%s: played frame %0d is out of order or unknown", row_name[r], i);
                end
                idx++;
            end
            if (got.size() == 0) begin
                errors++;
                $display("%s: no frame was played", row_name[r]);
            end
        end else begin
            if (got.size() != exp_q.size()) begin
                errors++;
                $display("%s: %0d frames played but %0d expected", row_name[r],
                         got.size(), exp_q.size());
            end
            for (int i = 0; i < got.size() && i < exp_q.size(); i++) begin
                check_frame(row_name[r], exp_q[i], got[i]);
            end
        end
    endtask

    initial begin
        int total;
        void'($urandom(32'h24cd));
        rst_ip = 1'b1;
        locked_i = 1'b1;
        valid_i = 1'b0;
        lrck_i = 1'b0;
        sample_i = '0;
        gain_l_i = 16'd256;
        gain_r_i = 16'd256;
        total = 0;
        for (int r = 0; r < NROWS; r++) begin
            total += row_cnt[r] / 2;
        end
        limit = (total + 3 * NROWS + 4) * FRAME_CYCLES;
        repeat (4) @(posedge clk491520);
        rst_ip <= 1'b0;
        while (zero_cnt < 1) begin
            @(posedge clk491520);
        end
        @(negedge clk491520);
        check_flag("reset overrun", 1'b0, overrun_o);
        check_flag("reset data", 1'b0, data_seen);
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
